/* hw/wb_cfg_pkg.sv */
// geometry is fixed for 32-bit byte addresses and 8-word lines and is not meant to be resized
package wb_cfg_pkg;

    // words per cache line and line width
    localparam int line_words = 8;
    localparam int line_bits  = line_words * 32;

    // queue entries, also the cache's starting credit count
    localparam int wb_depth = 5;
    localparam int cnt_bits = 3;

    // byte offset inside one line
    localparam int offset_bits  = 5;
    localparam int line_no_bits = 32 - offset_bits;

    // line number plus byte offset
    typedef struct packed {
        logic [line_no_bits-1:0] line;
        logic [offset_bits-1:0]  offset;
    } wb_addr_f_t;

    // one address word, seen either raw or split into line and offset
    typedef union packed {
        logic [31:0] raw;
        wb_addr_f_t  fld;
    } wb_addr_u;

endpackage

/* hw/axi_wr_pkg.sv */
// covers only single-line incrementing write bursts and the drain engine's state codes
package axi_wr_pkg;

    // eight beats per burst, encoded as len minus one
    localparam logic [7:0] burst_len  = 8'd7;

    // four bytes per beat
    localparam logic [2:0] burst_size = 3'd2;

    localparam logic [1:0] burst_incr = 2'b01;

    // beat counter wide enough for eight beats
    localparam int beat_bits = 3;

    // drain engine states
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1;
    localparam logic [1:0] st_data = 2'd2;
    localparam logic [1:0] st_resp = 2'd3;

endpackage

/* hw/wb_queue.sv */
// insert is never refused, so the cache must spend a credit first or the oldest entry is lost
`timescale 1ns/1ps

module wb_queue (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               ins_valid,
    input  wb_cfg_pkg::wb_addr_u               ins_addr,
    input  logic [wb_cfg_pkg::line_bits-1:0]   ins_line,
    input  logic                               head_pop,
    output logic                               head_valid,
    output wb_cfg_pkg::wb_addr_u               head_addr,
    output logic [wb_cfg_pkg::line_bits-1:0]   head_line,
    input  wb_cfg_pkg::wb_addr_u               query_addr,
    output logic                               query_hit,
    output logic [wb_cfg_pkg::line_bits-1:0]   query_line,
    output logic                               credit_ret,
    output logic [wb_cfg_pkg::cnt_bits-1:0]    count
);

    // slot 0 holds the newest line, only the line number is kept
    logic [wb_cfg_pkg::line_no_bits-1:0] line_mem [wb_cfg_pkg::wb_depth];
    logic [wb_cfg_pkg::line_bits-1:0]    data_mem [wb_cfg_pkg::wb_depth];

    logic [wb_cfg_pkg::cnt_bits-1:0] head_idx;

    // every insert shifts all slots up by one
    always_ff @(posedge clk) begin
        if (ins_valid) begin
            line_mem[0] <= ins_addr.fld.line;
            data_mem[0] <= ins_line;
            for (int i = 1; i < wb_cfg_pkg::wb_depth; i++) begin
                line_mem[i] <= line_mem[i-1];
                data_mem[i] <= data_mem[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (ins_valid && !head_pop) begin
            count <= count + 1'b1;
        end else if (head_pop && !ins_valid) begin
            count <= count - 1'b1;
        end
    end

    // oldest entry sits just below count
    assign head_valid = (count != '0);
    assign head_idx   = head_valid ? count - 1'b1 : '0;

    always_comb begin
        head_addr.fld.line   = line_mem[head_idx];
        head_addr.fld.offset = '0;
        head_line            = data_mem[head_idx];
    end

    // scan oldest to newest so the newest match wins
    always_comb begin
        query_hit  = 1'b0;
        query_line = '0;
        for (int i = wb_cfg_pkg::wb_depth - 1; i >= 0; i--) begin
            if ((wb_cfg_pkg::cnt_bits'(i) < count) &&
                (line_mem[i] == query_addr.fld.line)) begin
                query_hit  = 1'b1;
                query_line = data_mem[i];
            end
        end
    end

    // one credit back per entry that leaves
    assign credit_ret = head_pop;

endmodule

/* hw/wb_axi_drain.sv */
// drains one whole line per burst and does not look at the write response code
`timescale 1ns/1ps

module wb_axi_drain (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               head_valid,
    input  wb_cfg_pkg::wb_addr_u               head_addr,
    input  logic [wb_cfg_pkg::line_bits-1:0]   head_line,
    output logic                               head_pop,
    output logic                               awvalid,
    input  logic                               awready,
    output logic [31:0]                        awaddr,
    output logic [7:0]                         awlen,
    output logic [2:0]                         awsize,
    output logic [1:0]                         awburst,
    output logic                               wvalid,
    input  logic                               wready,
    output logic [31:0]                        wdata,
    output logic                               wlast,
    input  logic                               bvalid,
    output logic                               bready
);

    logic [1:0]                          state;
    logic [axi_wr_pkg::beat_bits-1:0]    beat;
    logic                                last_beat;

    // line copy taken when the burst starts
    logic [31:0]                                   addr_q;
    logic [wb_cfg_pkg::line_words-1:0][31:0]       line_q;

    assign last_beat = (beat == axi_wr_pkg::burst_len[axi_wr_pkg::beat_bits-1:0]);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= axi_wr_pkg::st_idle;
            beat  <= '0;
        end else begin
            case (state)
                axi_wr_pkg::st_idle: begin
                    if (head_valid) begin
                        state <= axi_wr_pkg::st_addr;
                    end
                end
                axi_wr_pkg::st_addr: begin
                    if (awready) begin
                        state <= axi_wr_pkg::st_data;
                        beat  <= '0;
                    end
                end
                axi_wr_pkg::st_data: begin
                    if (wready) begin
                        if (last_beat) begin
                            state <= axi_wr_pkg::st_resp;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                default: begin
                    // pop leaves the queue on this same edge
                    if (bvalid) begin
                        state <= axi_wr_pkg::st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == axi_wr_pkg::st_idle && head_valid) begin
            addr_q <= {head_addr.fld.line, {wb_cfg_pkg::offset_bits{1'b0}}};
            line_q <= head_line;
        end
    end

    assign awvalid = (state == axi_wr_pkg::st_addr);
    assign awaddr  = addr_q;
    assign awlen   = axi_wr_pkg::burst_len;
    assign awsize  = axi_wr_pkg::burst_size;
    assign awburst = axi_wr_pkg::burst_incr;

    // lowest word goes out first
    assign wvalid = (state == axi_wr_pkg::st_data);
    assign wdata  = line_q[beat];
    assign wlast  = wvalid && last_beat;

    assign bready   = (state == axi_wr_pkg::st_resp);
    assign head_pop = bready && bvalid;

endmodule

/* hw/wb_top.sv */
// write channel only, and the cache side must track its own credits
`timescale 1ns/1ps

module wb_top (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               ins_valid,
    input  wb_cfg_pkg::wb_addr_u               ins_addr,
    input  logic [wb_cfg_pkg::line_bits-1:0]   ins_line,
    input  wb_cfg_pkg::wb_addr_u               query_addr,
    output logic                               query_hit,
    output logic [wb_cfg_pkg::line_bits-1:0]   query_line,
    output logic                               credit_ret,
    output logic                               awvalid,
    input  logic                               awready,
    output logic [31:0]                        awaddr,
    output logic [7:0]                         awlen,
    output logic [2:0]                         awsize,
    output logic [1:0]                         awburst,
    output logic                               wvalid,
    input  logic                               wready,
    output logic [31:0]                        wdata,
    output logic                               wlast,
    input  logic                               bvalid,
    output logic                               bready
);

    logic                                head_valid;
    wb_cfg_pkg::wb_addr_u                head_addr;
    logic [wb_cfg_pkg::line_bits-1:0]    head_line;
    logic                                head_pop;
    // occupancy, compared by the testbench
    logic [wb_cfg_pkg::cnt_bits-1:0]     count;

    wb_queue u_queue (
        .clk        (clk),
        .rstn       (rstn),
        .ins_valid  (ins_valid),
        .ins_addr   (ins_addr),
        .ins_line   (ins_line),
        .head_pop   (head_pop),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_line  (head_line),
        .query_addr (query_addr),
        .query_hit  (query_hit),
        .query_line (query_line),
        .credit_ret (credit_ret),
        .count      (count)
    );

    wb_axi_drain u_drain (
        .clk        (clk),
        .rstn       (rstn),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_line  (head_line),
        .head_pop   (head_pop),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .awburst    (awburst),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wlast      (wlast),
        .bvalid     (bvalid),
        .bready     (bready)
    );

endmodule

/* verification/wb_props.sv */
// protocol checks for one-line write bursts only, read channels are not covered
`timescale 1ns/1ps

module wb_props (
    input logic        clk,
    input logic        rstn,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] awaddr,
    input logic        wvalid,
    input logic        wready,
    input logic [31:0] wdata,
    input logic        wlast,
    input logic        bvalid,
    input logic        bready,
    input logic        head_pop
);

    logic                             addr_done;
    logic [axi_wr_pkg::beat_bits-1:0] beats;
    int unsigned                      fails = 0;

    // burst between its address transfer and its last beat
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_done <= 1'b0;
            beats     <= '0;
        end else begin
            if (awvalid && awready) begin
                addr_done <= 1'b1;
            end
            if (wvalid && wready) begin
                beats <= beats + 1'b1;
                if (wlast) begin
                    addr_done <= 1'b0;
                end
            end
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("awvalid dropped or awaddr changed before acceptance");
            fails++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else begin
            $error("wvalid dropped or write data changed before acceptance");
            fails++;
        end

    last_beat: assert property (@(posedge clk) disable iff (!rstn)
        wvalid |-> (wlast == (beats == axi_wr_pkg::burst_len[axi_wr_pkg::beat_bits-1:0])))
        else begin
            $error("wlast not aligned with the eighth beat");
            fails++;
        end

    pop_on_resp: assert property (@(posedge clk) disable iff (!rstn)
        head_pop |-> bvalid && bready)
        else begin
            $error("head_pop without a response transfer");
            fails++;
        end

    w_after_aw: assert property (@(posedge clk) disable iff (!rstn)
        wvalid |-> addr_done)
        else begin
            $error("wvalid raised before the address transfer");
            fails++;
        end

endmodule

bind wb_axi_drain wb_props u_props (
    .clk      (clk),
    .rstn     (rstn),
    .awvalid  (awvalid),
    .awready  (awready),
    .awaddr   (awaddr),
    .wvalid   (wvalid),
    .wready   (wready),
    .wdata    (wdata),
    .wlast    (wlast),
    .bvalid   (bvalid),
    .bready   (bready),
    .head_pop (head_pop)
);

/* verification/wb_tb.sv */
// memory slave stalls at random from a fixed seed, and lines come from a small pool so duplicates occur
`timescale 1ns/1ps

module wb_tb;

    logic                              clk;
    logic                              rstn;
    logic                              ins_valid;
    wb_cfg_pkg::wb_addr_u              ins_addr;
    logic [wb_cfg_pkg::line_bits-1:0]  ins_line;
    wb_cfg_pkg::wb_addr_u              query_addr;
    logic                              query_hit;
    logic [wb_cfg_pkg::line_bits-1:0]  query_line;
    logic                              credit_ret;
    logic                              awvalid;
    logic                              awready;
    logic [31:0]                       awaddr;
    logic [7:0]                        awlen;
    logic [2:0]                        awsize;
    logic [1:0]                        awburst;
    logic                              wvalid;
    logic                              wready;
    logic [31:0]                       wdata;
    logic                              wlast;
    logic                              bvalid;
    logic                              bready;

    int seed     = 32'h6e4d37f4;
    int mem_seed = 32'h6e4d37f4 ^ 32'h0000ffff;
    int n_lines  = 45;
    int n_sent   = 0;
    int n_ret    = 0;
    int n_resp   = 0;
    int n_bursts = 0;
    int n_mismatch = 0;
    int n_other  = 0;
    int cycles   = 0;
    int beat_idx = 0;
    logic stall  = 1'b1;

    // expected bursts in insert order, and the model of the waiting entries
    wb_cfg_pkg::wb_addr_u             exp_addr [$];
    logic [wb_cfg_pkg::line_bits-1:0] exp_line [$];
    wb_cfg_pkg::wb_addr_u             mdl_addr [$];
    logic [wb_cfg_pkg::line_bits-1:0] mdl_line [$];
    wb_cfg_pkg::wb_addr_u             cur_addr;
    logic [wb_cfg_pkg::line_bits-1:0] cur_line;
    logic [wb_cfg_pkg::line_bits-1:0] beat_acc;

    wb_top DUT (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            n_mismatch++;
            $display("MISMATCH %s expected %0b actual %0b", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input wb_cfg_pkg::wb_addr_u exp,
                              input wb_cfg_pkg::wb_addr_u act);
        if (exp.raw !== act.raw) begin
            n_mismatch++;
            $display("MISMATCH %s expected %h actual %h", name, exp.raw, act.raw);
        end
    endtask

    task automatic check_line(input string name, input logic [wb_cfg_pkg::line_bits-1:0] exp,
                              input logic [wb_cfg_pkg::line_bits-1:0] act);
        if (exp !== act) begin
            n_mismatch++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [wb_cfg_pkg::cnt_bits-1:0] exp,
                               input logic [wb_cfg_pkg::cnt_bits-1:0] act);
        if (exp !== act) begin
            n_mismatch++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
    endtask

    // newest waiting copy wins, offset bits play no part
    function automatic logic ref_lookup(input wb_cfg_pkg::wb_addr_u q,
                                        output logic [wb_cfg_pkg::line_bits-1:0] line);
        logic hit;
        hit  = 1'b0;
        line = '0;
        for (int i = mdl_addr.size() - 1; i >= 0; i--) begin
            if (!hit && mdl_addr[i].fld.line == q.fld.line) begin
                hit  = 1'b1;
                line = mdl_line[i];
            end
        end
        return hit;
    endfunction

    function automatic int avail();
        return wb_cfg_pkg::wb_depth - n_sent + n_ret;
    endfunction

    // wide pool doubles the line numbers, half of them never inserted
    function automatic wb_cfg_pkg::wb_addr_u pick_addr(input logic wide);
        wb_cfg_pkg::wb_addr_u a;
        logic [31:0]          r;
        r          = $random(seed);
        a.raw      = r;
        a.fld.line = {23'h048d1, wide & r[11], r[10:8]};
        return a;
    endfunction

    function automatic logic [wb_cfg_pkg::line_bits-1:0] rand_line();
        logic [wb_cfg_pkg::line_bits-1:0] l;
        for (int w = 0; w < wb_cfg_pkg::line_words; w++) begin
            l[w*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    task automatic step(input logic ins, input wb_cfg_pkg::wb_addr_u a);
        @(posedge clk);
        #1;
        ins_valid  = ins;
        ins_addr   = a;
        ins_line   = ins ? rand_line() : '0;
        query_addr = pick_addr(1'b1);
        if (ins) begin
            n_sent++;
        end
    endtask

    // memory slave, bvalid follows the last beat by 0 to 3 cycles
    initial begin
        logic w_done;
        logic b_done;
        logic pending;
        int   delay;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        pending = 1'b0;
        delay   = 0;
        forever begin
            @(negedge clk);
            w_done = wvalid && wready && wlast;
            b_done = bvalid && bready;
            @(posedge clk);
            #1;
            awready = !stall && (($random(mem_seed) & 3) != 0);
            wready  = !stall && (($random(mem_seed) & 3) != 0);
            if (b_done) begin
                bvalid = 1'b0;
            end
            if (w_done) begin
                pending = 1'b1;
                delay   = $random(mem_seed) & 3;
            end
            if (pending) begin
                if (delay == 0) begin
                    bvalid  = 1'b1;
                    pending = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

    // compare process, samples mid-cycle and then updates the model
    always @(negedge clk) begin
        logic                             exp_hit;
        logic [wb_cfg_pkg::line_bits-1:0] exp_q;
        wb_cfg_pkg::wb_addr_u             got;
        wb_cfg_pkg::wb_addr_u             a;
        if (rstn) begin
            exp_hit = ref_lookup(query_addr, exp_q);
            check_bit("lookup hit", exp_hit, query_hit);
            if (exp_hit) begin
                check_line("lookup line", exp_q, query_line);
            end
            check_count("queue count", wb_cfg_pkg::cnt_bits'(mdl_addr.size()), DUT.count);
            if (awvalid && awready) begin
                if (exp_addr.size() == 0) begin
                    n_other++;
                    $display("burst started with no line waiting");
                end else begin
                    cur_addr = exp_addr.pop_front();
                    cur_line = exp_line.pop_front();
                end
                got.raw = awaddr;
                check_addr("burst address", cur_addr, got);
                // one line as eight incrementing beats of four bytes
                check_bit("burst fields", 1'b1, awlen == 8'd7 && awsize == 3'd2 &&
                          awburst == 2'b01);
                beat_idx = 0;
            end
            if (wvalid && wready) begin
                beat_acc[beat_idx*32 +: 32] = wdata;
                check_bit("wlast", beat_idx == wb_cfg_pkg::line_words - 1, wlast);
                if (beat_idx == wb_cfg_pkg::line_words - 1) begin
                    check_line("burst data", cur_line, beat_acc);
                    n_bursts++;
                end
                beat_idx++;
            end
            if (bvalid && bready) begin
                n_resp++;
            end
            if (ins_valid) begin
                a            = ins_addr;
                a.fld.offset = '0;
                exp_addr.push_back(a);
                exp_line.push_back(ins_line);
                mdl_addr.push_back(ins_addr);
                mdl_line.push_back(ins_line);
            end
            if (credit_ret) begin
                n_ret++;
                if (mdl_addr.size() == 0) begin
                    n_other++;
                    $display("credit returned with no line waiting");
                end else begin
                    mdl_addr.pop_front();
                    mdl_line.pop_front();
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * n_lines + 200) begin
            $display("timeout: bursts did not finish within %0d cycles", 40 * n_lines + 200);
            print_counts();
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        wb_cfg_pkg::wb_addr_u first;
        wb_cfg_pkg::wb_addr_u a;
        logic [31:0]          r;
        rstn       = 1'b0;
        ins_valid  = 1'b0;
        ins_addr   = '0;
        ins_line   = '0;
        query_addr = '0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_bit("reset awvalid", 1'b0, awvalid);
        check_bit("reset wvalid", 1'b0, wvalid);
        check_bit("reset bready", 1'b0, bready);
        check_bit("reset credit_ret", 1'b0, credit_ret);
        check_bit("reset query_hit", 1'b0, query_hit);

        // memory stalled, fill every credit and repeat the first line last
        first = pick_addr(1'b0);
        step(1'b1, first);
        while (avail() > 0) begin
            a = pick_addr(1'b0);
            if (avail() == 1) begin
                a.fld.line = first.fld.line;
            end
            step(1'b1, a);
        end
        repeat (20) begin
            step(1'b0, '0);
            query_addr.raw = first.raw ^ 32'h0000_001f;
        end
        check_bit("awvalid held under stall", 1'b1, awvalid);
        if (n_sent != wb_cfg_pkg::wb_depth || n_ret != 0) begin
            n_other++;
            $display("stalled fill took %0d inserts and returned %0d credits", n_sent, n_ret);
        end
        @(negedge clk);
        stall = 1'b0;

        while (n_sent < n_lines) begin
            r = $random(seed);
            if (avail() > 0 && r[1:0] != 2'd0) begin
                step(1'b1, pick_addr(1'b0));
            end else begin
                step(1'b0, '0);
            end
        end
        while (n_resp < n_sent) begin
            step(1'b0, '0);
        end
        repeat (4) step(1'b0, '0);

        if (n_ret != n_resp || n_bursts != n_sent || exp_addr.size() != 0) begin
            n_other++;
            $display("sent %0d lines, got %0d bursts, %0d responses, %0d credits",
                     n_sent, n_bursts, n_resp, n_ret);
        end
        if (DUT.u_drain.u_props.fails != 0) begin
            n_other++;
            $display("%0d protocol assertion failures on the memory port",
                     DUT.u_drain.u_props.fails);
        end
        print_counts();
        if (n_mismatch + n_other == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/wb_cfg_pkg.sv
hw/axi_wr_pkg.sv
hw/wb_queue.sv
hw/wb_axi_drain.sv
hw/wb_top.sv
verification/wb_props.sv
verification/wb_tb.sv

/* Makefile */
SIM      = verilator
TOP      = wb_tb
FILELIST = tb.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)
RUNFLAGS = +verilator+error+limit+1000
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))
PASS     = Test completed successfully

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNFLAGS))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(BUILD)
